/* logic/rv_pkg.sv */
////////////////////////////////////////////////////////////
// rv32i shared types: instruction formats, decoded command,
// stage transfer bundles and the one-hot phase encoding
////////////////////////////////////////////////////////////

package rv_pkg;

	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL   = 7'b1101111;
	localparam logic [6:0] OP_JALR  = 7'b1100111;
	localparam logic [6:0] OP_BR    = 7'b1100011;
	localparam logic [6:0] OP_LD    = 7'b0000011;
	localparam logic [6:0] OP_ST    = 7'b0100011;
	localparam logic [6:0] OP_ALUI  = 7'b0010011;
	localparam logic [6:0] OP_ALU   = 7'b0110011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word seen in all six formats
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	typedef struct packed {
		logic        lui;
		logic        auipc;
		logic        alu;
		logic        alui;
		logic        ld;
		logic        st;
		logic        jal;
		logic        jalr;
		logic        br;
		logic [2:0]  alu_code;    // funct3
		logic        alu_sub_sra;
		logic [4:0]  rd_adr;
		logic [4:0]  rs1_adr;
		logic [4:0]  rs2_adr;
		logic [31:0] imm;         // sign extended
		logic        wbk_rd_reg;  // rd written, never x0
	} dec_cmd_t;

	typedef struct packed {
		logic        ld;
		logic        st;
		logic [2:0]  ldst_code;
		logic [4:0]  rd_adr;
		logic        wbk_rd_reg;
		logic [31:0] rd_data;     // alu result or access address
		logic [31:0] st_data;
	} ma_cmd_t;

	typedef struct packed {
		logic        we;
		logic [4:0]  rd_adr;
		logic [31:0] data;
	} wb_t;

	// byte access when neither w nor hw is set
	typedef struct packed {
		logic        req;
		logic        w;
		logic        hw;
		logic [31:0] adr;
	} mem_req_t;

	typedef enum logic [4:0] {
		PH_PC    = 5'b00001,
		PH_IMR   = 5'b00010,
		PH_IDRFR = 5'b00100,
		PH_EX    = 5'b01000,
		PH_DMRW  = 5'b10000
	} phase_t;

endpackage

/* logic/cpu_state_machine.sv */
////////////////////////////////////////////////////////////
// cpu state machine
// run flag and one-hot phase sequencer
////////////////////////////////////////////////////////////

module cpu_state_machine (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_cpu_start,
	input  logic           i_quit_cmd,
	input  logic           i_imr_run,
	input  logic           i_dmrw_run,
	output rv_pkg::phase_t o_phase,
	output logic           o_running
);

	rv_pkg::phase_t phase_nxt;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_running <= 1'b0;
		end else if (i_cpu_start) begin
			o_running <= 1'b1;
		end else if (i_quit_cmd) begin
			o_running <= 1'b0; // instruction in flight still finishes
		end
	end

	always_comb begin
		phase_nxt = o_phase;
		case (o_phase)
			rv_pkg::PH_PC:    if (o_running) phase_nxt = rv_pkg::PH_IMR; // idle here when stopped
			rv_pkg::PH_IMR:   if (!i_imr_run) phase_nxt = rv_pkg::PH_IDRFR;
			rv_pkg::PH_IDRFR: phase_nxt = rv_pkg::PH_EX;
			rv_pkg::PH_EX:    phase_nxt = rv_pkg::PH_DMRW;
			rv_pkg::PH_DMRW:  if (!i_dmrw_run) phase_nxt = rv_pkg::PH_PC;
			default:          phase_nxt = rv_pkg::PH_PC;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_phase <= rv_pkg::PH_PC;
		end else begin
			o_phase <= phase_nxt;
		end
	end

	a_phase_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot(o_phase));

endmodule

/* logic/pc_stage.sv */
////////////////////////////////////////////////////////////
// pc stage
// word program counter, start load and next/jump update
////////////////////////////////////////////////////////////

module pc_stage (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_cpu_start,
	input  logic [31:2]    i_cpu_start_adr,
	input  rv_pkg::phase_t i_phase,
	input  logic           i_jmp_condition,
	input  logic [31:2]    i_jmp_adr,
	output logic [31:2]    o_pc
);

	logic dmrw_d; // previous cycle was DMRW

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			dmrw_d <= 1'b0;
			o_pc   <= '0;
		end else begin
			dmrw_d <= (i_phase == rv_pkg::PH_DMRW);
			if (i_cpu_start) begin
				o_pc <= i_cpu_start_adr;
			end else if (dmrw_d && i_phase == rv_pkg::PH_PC) begin
				// once per instruction, on the way back from DMRW
				o_pc <= i_jmp_condition ? i_jmp_adr : o_pc + 30'd1;
			end
		end
	end

endmodule

/* logic/inst_mem_read.sv */
////////////////////////////////////////////////////////////
// instruction memory read
// word fetch at pc, instruction latched on read valid
////////////////////////////////////////////////////////////

module inst_mem_read (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  rv_pkg::phase_t   i_phase,
	input  logic [31:2]      i_pc,
	input  logic             i_read_valid,
	input  logic [31:0]      i_read_data,
	output logic             o_imr_run,
	output rv_pkg::mem_req_t o_i_read,
	output rv_pkg::inst_u    o_inst
);

	logic got; // fetch answered this IMR
	logic take;

	assign take = o_i_read.req && i_read_valid;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			got <= 1'b0;
		end else if (i_phase != rv_pkg::PH_IMR) begin
			got <= 1'b0;
		end else if (take) begin
			got <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) o_inst <= i_read_data;
	end

	// request level held from IMR entry until valid
	assign o_i_read = '{req: (i_phase == rv_pkg::PH_IMR) && !got, w: 1'b1, hw: 1'b0,
		adr: {i_pc, 2'b00}};
	assign o_imr_run = !got;

	a_req_fall_after_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$fell(o_i_read.req) |-> $past(i_read_valid));

endmodule

/* logic/decoder.sv */
////////////////////////////////////////////////////////////
// instruction decoder
// format select, immediate assembly and command flags
////////////////////////////////////////////////////////////

module decoder (
	input  rv_pkg::inst_u    i_inst,
	output rv_pkg::dec_cmd_t o_cmd
);

	always_comb begin
		o_cmd          = '0;
		o_cmd.alu_code = i_inst.r.funct3;
		o_cmd.rd_adr   = i_inst.r.rd;
		o_cmd.rs1_adr  = i_inst.r.rs1;
		o_cmd.rs2_adr  = i_inst.r.rs2;
		case (i_inst.r.opcode)
			rv_pkg::OP_LUI: begin
				o_cmd.lui = 1'b1;
				o_cmd.imm = {i_inst.u.imm_31_12, 12'd0};
			end
			rv_pkg::OP_AUIPC: begin
				o_cmd.auipc = 1'b1;
				o_cmd.imm   = {i_inst.u.imm_31_12, 12'd0};
			end
			rv_pkg::OP_JAL: begin
				o_cmd.jal = 1'b1;
				o_cmd.imm = {{11{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
					i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};
			end
			rv_pkg::OP_JALR: begin
				o_cmd.jalr = 1'b1;
				o_cmd.imm  = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
			end
			rv_pkg::OP_BR: begin
				o_cmd.br  = 1'b1;
				o_cmd.imm = {{19{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
					i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
			end
			rv_pkg::OP_LD: begin
				o_cmd.ld  = 1'b1;
				o_cmd.imm = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
			end
			rv_pkg::OP_ST: begin
				o_cmd.st  = 1'b1;
				o_cmd.imm = {{20{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
			end
			rv_pkg::OP_ALUI: begin
				o_cmd.alui        = 1'b1;
				o_cmd.imm         = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
				o_cmd.alu_sub_sra = (i_inst.r.funct3 == 3'b101) && i_inst.r.funct7[5]; // srai only
			end
			rv_pkg::OP_ALU: begin
				o_cmd.alu         = 1'b1;
				o_cmd.alu_sub_sra = i_inst.r.funct7[5]; // sub, sra
			end
			default: ; // fence, system and unknown run as no-ops
		endcase
		o_cmd.wbk_rd_reg = (o_cmd.lui | o_cmd.auipc | o_cmd.alu | o_cmd.alui | o_cmd.ld |
			o_cmd.jal | o_cmd.jalr) && (i_inst.r.rd != 5'd0);
	end

endmodule

/* logic/register_file.sv */
////////////////////////////////////////////////////////////
// register file, 32 x 32 with x0 hardwired to zero
////////////////////////////////////////////////////////////

module register_file (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  rv_pkg::phase_t i_phase,
	input  logic [4:0]     i_rs1_adr,
	input  logic [4:0]     i_rs2_adr,
	input  rv_pkg::wb_t    i_wb,
	output logic [31:0]    o_rs1_data,
	output logic [31:0]    o_rs2_data
);

	logic [31:0] regs [1:31]; // no storage for x0

	always_ff @(posedge i_clk) begin
		if (i_wb.we && i_wb.rd_adr != 5'd0) regs[i_wb.rd_adr] <= i_wb.data;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rs1_data <= '0;
			o_rs2_data <= '0;
		end else if (i_phase == rv_pkg::PH_IDRFR) begin
			o_rs1_data <= (i_rs1_adr == 5'd0) ? 32'd0 : regs[i_rs1_adr];
			o_rs2_data <= (i_rs2_adr == 5'd0) ? 32'd0 : regs[i_rs2_adr];
		end
	end

endmodule

/* logic/execution.sv */
////////////////////////////////////////////////////////////
// execution stage
// alu, branch compare, jump target and memory request build
////////////////////////////////////////////////////////////

module execution (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  rv_pkg::phase_t   i_phase,
	input  logic [31:2]      i_pc,
	input  rv_pkg::dec_cmd_t i_cmd,
	input  logic [31:0]      i_rs1_data,
	input  logic [31:0]      i_rs2_data,
	output rv_pkg::ma_cmd_t  o_ma,
	output logic             o_jmp_condition,
	output logic [31:2]      o_jmp_adr
);

	logic [31:0] pc32;
	logic [31:0] op2;
	logic [31:0] alu_res;
	logic [31:0] result;
	logic [31:0] target;
	logic        taken;

	assign pc32 = {i_pc, 2'b00};
	assign op2  = i_cmd.alu ? i_rs2_data : i_cmd.imm;

	always_comb begin
		case (i_cmd.alu_code)
			3'b000:  alu_res = i_cmd.alu_sub_sra ? i_rs1_data - op2 : i_rs1_data + op2;
			3'b001:  alu_res = i_rs1_data << op2[4:0];
			3'b010:  alu_res = {31'd0, $signed(i_rs1_data) < $signed(op2)};
			3'b011:  alu_res = {31'd0, i_rs1_data < op2};
			3'b100:  alu_res = i_rs1_data ^ op2;
			3'b101:  alu_res = i_cmd.alu_sub_sra ? $unsigned($signed(i_rs1_data) >>> op2[4:0])
				: i_rs1_data >> op2[4:0];
			3'b110:  alu_res = i_rs1_data | op2;
			default: alu_res = i_rs1_data & op2;
		endcase
	end

	always_comb begin
		if (i_cmd.lui) result = i_cmd.imm;
		else if (i_cmd.auipc) result = pc32 + i_cmd.imm;
		else if (i_cmd.jal || i_cmd.jalr) result = pc32 + 32'd4; // link
		else if (i_cmd.ld || i_cmd.st) result = i_rs1_data + i_cmd.imm; // access address
		else result = alu_res;
	end

	// branch compare keyed on funct3
	always_comb begin
		case (i_cmd.alu_code)
			3'b000:  taken = (i_rs1_data == i_rs2_data);
			3'b001:  taken = (i_rs1_data != i_rs2_data);
			3'b100:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
			3'b101:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
			3'b110:  taken = (i_rs1_data < i_rs2_data);
			3'b111:  taken = (i_rs1_data >= i_rs2_data);
			default: taken = 1'b0;
		endcase
	end

	assign target = i_cmd.jalr ? ((i_rs1_data + i_cmd.imm) & ~32'd1) : pc32 + i_cmd.imm;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ma            <= '0;
			o_jmp_condition <= 1'b0;
			o_jmp_adr       <= '0;
		end else if (i_phase == rv_pkg::PH_EX) begin
			o_ma.ld         <= i_cmd.ld;
			o_ma.st         <= i_cmd.st;
			o_ma.ldst_code  <= i_cmd.alu_code;
			o_ma.rd_adr     <= i_cmd.rd_adr;
			o_ma.wbk_rd_reg <= i_cmd.wbk_rd_reg;
			o_ma.rd_data    <= result;
			o_ma.st_data    <= i_rs2_data;
			o_jmp_condition <= i_cmd.jal | i_cmd.jalr | (i_cmd.br & taken);
			o_jmp_adr       <= target[31:2];
		end
	end

endmodule

/* logic/data_rw_mem.sv */
////////////////////////////////////////////////////////////
// data memory read/write
// load/store requests, lane alignment and writeback
////////////////////////////////////////////////////////////

module data_rw_mem (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  rv_pkg::phase_t   i_phase,
	input  rv_pkg::ma_cmd_t  i_ma,
	input  logic             i_read_valid,
	input  logic [31:0]      i_read_data,
	input  logic             i_write_finish,
	output rv_pkg::mem_req_t o_d_read,
	output rv_pkg::mem_req_t o_d_write,
	output logic [31:0]      o_d_write_data,
	output logic             o_dmrw_run,
	output rv_pkg::wb_t      o_wb
);

	logic        in_dmrw;
	logic        done;    // access answered
	logic        ld_take;
	logic        w_sz;
	logic        hw_sz;
	logic [31:0] rd_word; // addressed lane moved to bit 0
	logic [31:0] ld_ext;
	logic [31:0] ld_data;

	assign in_dmrw = (i_phase == rv_pkg::PH_DMRW);
	assign w_sz    = (i_ma.ldst_code[1:0] == 2'b10);
	assign hw_sz   = (i_ma.ldst_code[1:0] == 2'b01);
	assign ld_take = o_d_read.req && i_read_valid;

	assign o_d_read  = '{req: in_dmrw && i_ma.ld && !done, w: w_sz, hw: hw_sz,
		adr: i_ma.rd_data};
	assign o_d_write = '{req: in_dmrw && i_ma.st && !done, w: w_sz, hw: hw_sz,
		adr: i_ma.rd_data};
	assign o_d_write_data = i_ma.st_data << {i_ma.rd_data[1:0], 3'b000}; // into byte lane

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			done <= 1'b0;
		end else if (!in_dmrw) begin
			done <= 1'b0;
		end else if (ld_take || (o_d_write.req && i_write_finish)) begin
			done <= 1'b1;
		end
	end

	// read word is the aligned word holding the address
	always_comb begin
		rd_word = i_read_data >> {i_ma.rd_data[1:0], 3'b000};
		case (i_ma.ldst_code)
			3'b000:  ld_ext = {{24{rd_word[7]}}, rd_word[7:0]};
			3'b001:  ld_ext = {{16{rd_word[15]}}, rd_word[15:0]};
			3'b100:  ld_ext = {24'd0, rd_word[7:0]};
			3'b101:  ld_ext = {16'd0, rd_word[15:0]};
			default: ld_ext = rd_word;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (ld_take) ld_data <= ld_ext;
	end

	assign o_dmrw_run = (i_ma.ld | i_ma.st) && !done;
	assign o_wb = '{we: in_dmrw && !o_dmrw_run && i_ma.wbk_rd_reg, rd_adr: i_ma.rd_adr,
		data: i_ma.ld ? ld_data : i_ma.rd_data};

	a_no_rd_wr_overlap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_d_read.req && o_d_write.req));

endmodule

/* logic/cpu_top.sv */
////////////////////////////////////////////////////////////
// rv32i multi-cycle cpu top, shared memory port
////////////////////////////////////////////////////////////

module cpu_top (
	input  logic        clk,
	input  logic        i_rst_n,
	input  logic        i_cpu_start,
	input  logic        i_quit_cmd,
	input  logic [31:2] i_cpu_start_adr,
	output logic [31:0] o_pc_data,
	output logic        o_i_read_req,
	output logic        o_i_read_w,
	output logic        o_i_read_hw,
	output logic [31:0] o_i_read_adr,
	output logic        o_d_read_req,
	output logic        o_d_read_w,
	output logic        o_d_read_hw,
	output logic [31:0] o_d_read_adr,
	input  logic        i_read_valid,
	input  logic [31:0] i_read_data,
	output logic        o_d_write_req,
	output logic        o_d_write_w,
	output logic        o_d_write_hw,
	output logic [31:0] o_d_write_adr,
	output logic [31:0] o_d_write_data,
	input  logic        i_write_finish
);

	rv_pkg::phase_t   phase;
	logic             imr_run;
	logic             dmrw_run;
	logic [31:2]      pc;
	rv_pkg::inst_u    inst;
	rv_pkg::dec_cmd_t cmd;
	logic [31:0]      rs1_data;
	logic [31:0]      rs2_data;
	rv_pkg::ma_cmd_t  ma;
	logic             jmp_condition;
	logic [31:2]      jmp_adr;
	rv_pkg::wb_t      wb;
	rv_pkg::mem_req_t i_read;
	rv_pkg::mem_req_t d_read;
	rv_pkg::mem_req_t d_write;

	assign o_pc_data     = {pc, 2'b00};
	assign o_i_read_req  = i_read.req;
	assign o_i_read_w    = i_read.w;
	assign o_i_read_hw   = i_read.hw;
	assign o_i_read_adr  = i_read.adr;
	assign o_d_read_req  = d_read.req;
	assign o_d_read_w    = d_read.w;
	assign o_d_read_hw   = d_read.hw;
	assign o_d_read_adr  = d_read.adr;
	assign o_d_write_req = d_write.req;
	assign o_d_write_w   = d_write.w;
	assign o_d_write_hw  = d_write.hw;
	assign o_d_write_adr = d_write.adr;

	cpu_state_machine cpu_state_machine (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start),
		.i_quit_cmd(i_quit_cmd),
		.i_imr_run(imr_run),
		.i_dmrw_run(dmrw_run),
		.o_phase(phase),
		.o_running() // status only
	);

	pc_stage pc_stage (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_cpu_start(i_cpu_start),
		.i_cpu_start_adr(i_cpu_start_adr),
		.i_phase(phase),
		.i_jmp_condition(jmp_condition),
		.i_jmp_adr(jmp_adr),
		.o_pc(pc)
	);

	inst_mem_read inst_mem_read (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_phase(phase),
		.i_pc(pc),
		.i_read_valid(i_read_valid),
		.i_read_data(i_read_data),
		.o_imr_run(imr_run),
		.o_i_read(i_read),
		.o_inst(inst)
	);

	decoder decoder (
		.i_inst(inst),
		.o_cmd(cmd)
	);

	register_file register_file (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_phase(phase),
		.i_rs1_adr(cmd.rs1_adr),
		.i_rs2_adr(cmd.rs2_adr),
		.i_wb(wb),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	execution execution (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_phase(phase),
		.i_pc(pc),
		.i_cmd(cmd),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_ma(ma),
		.o_jmp_condition(jmp_condition),
		.o_jmp_adr(jmp_adr)
	);

	data_rw_mem data_rw_mem (
		.i_clk(clk),
		.i_rst_n(i_rst_n),
		.i_phase(phase),
		.i_ma(ma),
		.i_read_valid(i_read_valid),
		.i_read_data(i_read_data),
		.i_write_finish(i_write_finish),
		.o_d_read(d_read),
		.o_d_write(d_write),
		.o_d_write_data(o_d_write_data),
		.o_dmrw_run(dmrw_run),
		.o_wb(wb)
	);

endmodule

/* tb/tb_mem_model.sv */
////////////////////////////////////////////////////////////
// shared memory model
// byte array answering reads and writes with seeded random latency
////////////////////////////////////////////////////////////

module tb_mem_model (
	input  logic        i_clk,
	input  logic        i_i_read_req,
	input  logic [31:0] i_i_read_adr,
	input  logic        i_d_read_req,
	input  logic [31:0] i_d_read_adr,
	input  logic        i_d_write_req,
	input  logic        i_d_write_w,
	input  logic        i_d_write_hw,
	input  logic [31:0] i_d_write_adr,
	input  logic [31:0] i_d_write_data,
	output logic        o_read_valid = 1'b0,
	output logic [31:0] o_read_data = 32'd0,
	output logic        o_write_finish = 1'b0
);

	logic [7:0]  mem [0:4095];
	logic        pending = 1'b0;
	logic [2:0]  wait_cnt = 3'd0;
	logic [11:0] base;
	integer      seed;

	initial begin
		seed = 92413;
		for (int a = 0; a < 4096; a++) begin
			mem[a] = 8'(a) ^ {4'(a >> 8), 4'(a >> 8)} ^ 8'h5a; // every address bit counts
		end
	end

	task put_word(input logic [31:0] adr, input logic [31:0] data);
		for (int k = 0; k < 4; k++) begin
			mem[adr[11:0] + 12'(k)] = data[8*k +: 8];
		end
	endtask

	// outputs change a little after the edge
	always @(posedge i_clk) begin
		#1;
		o_read_valid   = 1'b0;
		o_write_finish = 1'b0;
		if (!pending) begin
			if (i_i_read_req || i_d_read_req || i_d_write_req) begin
				pending  = 1'b1;
				wait_cnt = 3'd1 + 3'($unsigned($random(seed)) % 4);
			end
		end else begin
			wait_cnt = wait_cnt - 3'd1;
			if (wait_cnt == 3'd0) begin
				pending = 1'b0;
				if (i_d_write_req) begin
					base = {i_d_write_adr[11:2], 2'b00};
					for (int k = 0; k < 4; k++) begin
						if (i_d_write_w || (i_d_write_hw && (k / 2) == (i_d_write_adr[1] ? 1 : 0))
							|| (!i_d_write_hw && k == int'(i_d_write_adr[1:0])))
							mem[base + 12'(k)] = i_d_write_data[8*k +: 8];
					end
					o_write_finish = 1'b1;
				end else begin
					base = i_i_read_req ? {i_i_read_adr[11:2], 2'b00} : {i_d_read_adr[11:2], 2'b00};
					o_read_data  = {mem[base + 12'd3], mem[base + 12'd2], mem[base + 12'd1],
						mem[base]};
					o_read_valid = 1'b1;
				end
			end
		end
	end

endmodule

/* tb/tb_cpu_top.sv */
////////////////////////////////////////////////////////////
// testbench for the rv32i core
// program results checked by assertions on the memory write port
////////////////////////////////////////////////////////////

module tb_cpu_top;

	localparam logic [31:0] START_ADR = 32'h0000_0100;
	localparam logic [31:0] RES_BASE  = 32'h0000_0400;
	localparam logic [31:0] DATA_ADR  = 32'h0000_0600;
	localparam logic [31:0] POISON    = 32'hffff_fbad;
	localparam int          WAIT_LIMIT = 20000;
	localparam logic [1:0]  SZ_W = 2'b10; // {w, hw} of a word access
	localparam logic [1:0]  SZ_H = 2'b01;
	localparam logic [1:0]  SZ_B = 2'b00;

	logic        clk = 1'b0;
	logic        rst_n, cpu_start, quit_cmd;
	logic [31:2] start_adr;
	logic [31:0] o_pc_data, o_i_read_adr, o_d_read_adr, o_d_write_adr, o_d_write_data;
	logic        o_i_read_req, o_i_read_w, o_i_read_hw;
	logic        o_d_read_req, o_d_read_w, o_d_read_hw;
	logic        o_d_write_req, o_d_write_w, o_d_write_hw;
	logic        read_valid, write_finish;
	logic [31:0] read_data;

	logic [31:0] exp_tab [0:63];
	logic        seen [0:63];
	logic [6:0]  n_exp = 7'd0;
	logic [1:0]  ld_sz [0:15]; // expected size of each load in program order
	logic [3:0]  n_ld = 4'd0;
	logic [3:0]  ld_done;
	int          stores_done = 0;
	int          assert_errors = 0;
	int          missing = 0;
	logic [31:0] pc_w;
	logic [31:0] park_adr;
	logic        started = 1'b0, quiet = 1'b0, hung = 1'b0, first_fetch;
	logic        st_fire, in_table;
	logic [31:0] st_off, exp_val;
	int          cnt, idle;

	always #4 clk = ~clk;

	cpu_top uut (
		.clk(clk), .i_rst_n(rst_n), .i_cpu_start(cpu_start), .i_quit_cmd(quit_cmd),
		.i_cpu_start_adr(start_adr), .o_pc_data(o_pc_data),
		.o_i_read_req(o_i_read_req), .o_i_read_w(o_i_read_w), .o_i_read_hw(o_i_read_hw),
		.o_i_read_adr(o_i_read_adr), .o_d_read_req(o_d_read_req), .o_d_read_w(o_d_read_w),
		.o_d_read_hw(o_d_read_hw), .o_d_read_adr(o_d_read_adr), .i_read_valid(read_valid),
		.i_read_data(read_data), .o_d_write_req(o_d_write_req), .o_d_write_w(o_d_write_w),
		.o_d_write_hw(o_d_write_hw), .o_d_write_adr(o_d_write_adr),
		.o_d_write_data(o_d_write_data), .i_write_finish(write_finish)
	);

	tb_mem_model mem (
		.i_clk(clk), .i_i_read_req(o_i_read_req), .i_i_read_adr(o_i_read_adr),
		.i_d_read_req(o_d_read_req), .i_d_read_adr(o_d_read_adr),
		.i_d_write_req(o_d_write_req), .i_d_write_w(o_d_write_w), .i_d_write_hw(o_d_write_hw),
		.i_d_write_adr(o_d_write_adr), .i_d_write_data(o_d_write_data),
		.o_read_valid(read_valid), .o_read_data(read_data), .o_write_finish(write_finish)
	);

	assign st_fire  = o_d_write_req && write_finish;
	assign st_off   = o_d_write_adr - RES_BASE;
	assign in_table = o_d_write_w && (o_d_write_adr >= RES_BASE) && (st_off[31:2] < {23'd0, n_exp});
	assign exp_val  = exp_tab[st_off[7:2]];

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_fetch <= 1'b1;
			ld_done     <= 4'd0;
			for (int k = 0; k < 64; k++) seen[k] <= 1'b0;
		end else begin
			if (o_i_read_req) first_fetch <= 1'b0;
			if (o_d_read_req && read_valid) ld_done <= ld_done + 4'd1;
			if (st_fire && in_table && !seen[st_off[7:2]]) begin
				seen[st_off[7:2]] <= 1'b1;
				stores_done       <= stores_done + 1;
			end
		end
	end

	a_idle_before_start: assert property (@(posedge clk)
		!started |-> !(o_i_read_req || o_d_read_req || o_d_write_req))
		else begin
			assert_errors++;
			$display("memory request raised during reset or before start at %0t", $time);
		end

	a_first_fetch_adr: assert property (@(posedge clk) disable iff (!rst_n)
		(first_fetch && o_i_read_req) |-> (o_i_read_adr == START_ADR))
		else begin
			assert_errors++;
			$display("error %0t: o_i_read_adr is %h, expected %h", $time,
				$sampled(o_i_read_adr), START_ADR);
		end

	a_fetch_word: assert property (@(posedge clk) disable iff (!rst_n)
		o_i_read_req |-> (o_i_read_w && !o_i_read_hw))
		else begin
			assert_errors++;
			$display("error %0t: o_i_read_w/hw is %b%b, expected %b", $time,
				$sampled(o_i_read_w), $sampled(o_i_read_hw), SZ_W);
		end

	a_load_size: assert property (@(posedge clk) disable iff (!rst_n)
		(o_d_read_req && read_valid) |-> ({o_d_read_w, o_d_read_hw} == ld_sz[ld_done]))
		else begin
			assert_errors++;
			$display("error %0t: o_d_read_w/hw is %b%b, expected %b", $time,
				$sampled(o_d_read_w), $sampled(o_d_read_hw), $sampled(ld_sz[ld_done]));
		end

	a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
		(st_fire && in_table) |-> (o_d_write_data == exp_val))
		else begin
			assert_errors++;
			$display("error %0t: o_d_write_data at %h is %h, expected %h", $time,
				$sampled(o_d_write_adr), $sampled(o_d_write_data), $sampled(exp_val));
		end

	a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
		st_fire |-> (o_d_write_data != POISON))
		else begin
			assert_errors++;
			$display("error %0t: o_d_write_data is %h, skipped store value %h", $time,
				$sampled(o_d_write_data), POISON);
		end

	a_quiet_after_quit: assert property (@(posedge clk) disable iff (!rst_n)
		quiet |-> (!o_i_read_req && !o_d_read_req))
		else begin
			assert_errors++;
			$display("core still active after quit at %0t", $time);
		end

	a_pc_parked: assert property (@(posedge clk) disable iff (!rst_n)
		quiet |-> (o_pc_data == park_adr))
		else begin
			assert_errors++;
			$display("error %0t: o_pc_data is %h, expected %h", $time,
				$sampled(o_pc_data), park_adr);
		end

	function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_ST};
	endfunction

	function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BR};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
	endfunction

	task emit(input logic [31:0] w);
		mem.put_word(pc_w, w);
		pc_w = pc_w + 32'd4;
	endtask

	// store rs to the next result slot and remember its value
	task check_reg(input logic [4:0] rs, input logic [31:0] val);
		emit(enc_s({23'd0, n_exp, 2'b00}, rs, 5'd31, 3'b010));
		exp_tab[n_exp[5:0]] = val;
		n_exp = n_exp + 7'd1;
	endtask

	task op_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] val);
		emit({f7, rs2, rs1, f3, rd, rv_pkg::OP_ALU});
		check_reg(rd, val);
	endtask

	task op_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [31:0] imm, input logic [31:0] val);
		emit(enc_i(imm, rs1, f3, rd, rv_pkg::OP_ALUI));
		check_reg(rd, val);
	endtask

	task load_check(input logic [2:0] f3, input logic [1:0] sz, input logic [31:0] off,
		input logic [31:0] val);
		emit(enc_i(off, 5'd24, f3, 5'd25, rv_pkg::OP_LD));
		ld_sz[n_ld] = sz;
		n_ld = n_ld + 4'd1;
		check_reg(5'd25, val);
	endtask

	task build_program;
		logic [31:0] here;
		pc_w = START_ADR;
		mem.put_word(DATA_ADR, 32'h80f1_7f84);
		emit(enc_i(RES_BASE, 5'd0, 3'b000, 5'd31, rv_pkg::OP_ALUI));
		emit(enc_i(-32'sd7, 5'd0, 3'b000, 5'd1, rv_pkg::OP_ALUI)); // x1 = -7
		emit(enc_i(32'd100, 5'd0, 3'b000, 5'd2, rv_pkg::OP_ALUI));
		emit(enc_i(POISON, 5'd0, 3'b000, 5'd30, rv_pkg::OP_ALUI));
		emit(enc_i(32'd5, 5'd0, 3'b000, 5'd10, rv_pkg::OP_ALUI));
		op_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2, 32'd93);
		op_r(7'h20, 3'b000, 5'd4, 5'd1, 5'd2, 32'hffff_ff95);
		op_r(7'h00, 3'b111, 5'd5, 5'd1, 5'd2, 32'h0000_0060);
		op_r(7'h00, 3'b110, 5'd6, 5'd1, 5'd2, 32'hffff_fffd);
		op_r(7'h00, 3'b100, 5'd7, 5'd1, 5'd2, 32'hffff_ff9d);
		op_r(7'h00, 3'b010, 5'd8, 5'd1, 5'd2, 32'd1);
		op_r(7'h00, 3'b011, 5'd9, 5'd1, 5'd2, 32'd0);
		op_r(7'h00, 3'b001, 5'd11, 5'd2, 5'd10, 32'h0000_0c80);
		op_r(7'h00, 3'b101, 5'd12, 5'd1, 5'd10, 32'h07ff_ffff);
		op_r(7'h20, 3'b101, 5'd13, 5'd1, 5'd10, 32'hffff_ffff);
		op_i(3'b001, 5'd14, 5'd1, 32'd4, 32'hffff_ff90);
		op_i(3'b101, 5'd15, 5'd1, 32'd28, 32'h0000_000f);
		op_i(3'b101, 5'd16, 5'd1, 32'h401, 32'hffff_fffc); // srai 1
		op_i(3'b111, 5'd17, 5'd1, 32'h0f0, 32'h0000_00f0);
		op_i(3'b110, 5'd18, 5'd2, 32'hf00, 32'hffff_ff64);
		op_i(3'b100, 5'd19, 5'd1, 32'hfff, 32'd6);
		op_i(3'b010, 5'd20, 5'd1, -32'sd6, 32'd1);
		op_i(3'b011, 5'd21, 5'd2, 32'hfff, 32'd1);
		emit({20'h12345, 5'd22, rv_pkg::OP_LUI});
		check_reg(5'd22, 32'h1234_5000);
		here = pc_w;
		emit({20'h00001, 5'd23, rv_pkg::OP_AUIPC});
		check_reg(5'd23, here + 32'h1000);
		emit(enc_i(DATA_ADR, 5'd0, 3'b000, 5'd24, rv_pkg::OP_ALUI));
		load_check(3'b010, SZ_W, 32'd0, 32'h80f1_7f84);
		load_check(3'b000, SZ_B, 32'd0, 32'hffff_ff84);
		load_check(3'b100, SZ_B, 32'd0, 32'h0000_0084);
		load_check(3'b000, SZ_B, 32'd1, 32'h0000_007f);
		load_check(3'b001, SZ_H, 32'd2, 32'hffff_80f1);
		load_check(3'b101, SZ_H, 32'd2, 32'h0000_80f1);
		load_check(3'b001, SZ_H, 32'd0, 32'h0000_7f84);
		load_check(3'b100, SZ_B, 32'd3, 32'h0000_0080);
		emit(enc_s(32'd1, 5'd2, 5'd24, 3'b000)); // sb into lane 1
		emit(enc_s(32'd2, 5'd1, 5'd24, 3'b001)); // sh into upper half
		load_check(3'b010, SZ_W, 32'd0, 32'hfff9_6484);
		// taken branches skip the poison store and not taken ones count in x27
		emit(enc_i(32'd0, 5'd0, 3'b000, 5'd27, rv_pkg::OP_ALUI));
		for (int k = 0; k < 12; k++) begin
			logic [2:0] f3;
			logic [4:0] a, b;
			f3 = (k % 6 < 2) ? 3'(k % 6) : 3'(k % 6 + 2);
			case (k)
				0:       {a, b} = {5'd9, 5'd0};
				1:       {a, b} = {5'd1, 5'd2};
				2:       {a, b} = {5'd1, 5'd2};
				3:       {a, b} = {5'd2, 5'd1};
				4:       {a, b} = {5'd2, 5'd1};
				5:       {a, b} = {5'd1, 5'd2};
				6:       {a, b} = {5'd1, 5'd2};
				7:       {a, b} = {5'd9, 5'd0};
				8:       {a, b} = {5'd2, 5'd1};
				9:       {a, b} = {5'd1, 5'd2};
				10:      {a, b} = {5'd1, 5'd2};
				default: {a, b} = {5'd2, 5'd1};
			endcase
			emit(enc_b(32'd8, b, a, f3));
			if (k < 6) emit(enc_s(32'h3f0, 5'd30, 5'd31, 3'b010));
			else emit(enc_i(32'd1, 5'd27, 3'b000, 5'd27, rv_pkg::OP_ALUI));
		end
		check_reg(5'd27, 32'd6);
		here = pc_w;
		emit(enc_j(32'd8, 5'd28));
		emit(enc_s(32'h3f0, 5'd30, 5'd31, 3'b010));
		check_reg(5'd28, here + 32'd4);
		here = pc_w;
		emit({20'h00000, 5'd29, rv_pkg::OP_AUIPC});
		emit(enc_i(32'd13, 5'd29, 3'b000, 5'd26, rv_pkg::OP_JALR)); // low bit dropped
		emit(enc_s(32'h3f0, 5'd30, 5'd31, 3'b010));
		check_reg(5'd26, here + 32'd8);
		emit(enc_i(32'd55, 5'd0, 3'b000, 5'd0, rv_pkg::OP_ALUI));
		check_reg(5'd0, 32'd0);
		park_adr = pc_w;
		emit(enc_j(32'd0, 5'd0)); // park in a self loop
	endtask

	initial begin
		rst_n     = 1'b0;
		cpu_start = 1'b0;
		quit_cmd  = 1'b0;
		start_adr = START_ADR[31:2];
		repeat (4) @(posedge clk);
		build_program();
		#1 rst_n = 1'b1;
		repeat (3) @(posedge clk);
		#1 cpu_start = 1'b1;
		started = 1'b1;
		@(posedge clk);
		#1 cpu_start = 1'b0;
		cnt = 0;
		while (!o_i_read_req && cnt < 100) begin
			@(posedge clk);
			cnt++;
		end
		if (!o_i_read_req) begin
			hung = 1'b1;
			$display("timeout waiting for the first instruction fetch");
		end
		cnt = 0;
		while (!hung && stores_done < int'(n_exp) && cnt < WAIT_LIMIT) begin
			@(posedge clk);
			cnt++;
		end
		if (!hung && stores_done < int'(n_exp)) begin
			hung = 1'b1;
			$display("timeout waiting for result stores, %0d of %0d seen", stores_done, n_exp);
		end
		if (!hung) begin
			@(posedge clk);
			#1 quit_cmd = 1'b1;
			@(posedge clk);
			#1 quit_cmd = 1'b0;
			cnt  = 0;
			idle = 0;
			while (idle < 8 && cnt < 200) begin
				@(posedge clk);
				idle = o_i_read_req ? 0 : idle + 1;
				cnt++;
			end
			if (idle < 8) begin
				hung = 1'b1;
				$display("timeout waiting for the core to stop after quit");
			end else begin
				#1 quiet = 1'b1;
				repeat (60) @(posedge clk);
				#1 quiet = 1'b0;
			end
		end
		for (int k = 0; k < int'(n_exp); k++) begin
			if (!seen[k]) missing++;
		end
		$display("assertion errors %0d, missing stores %0d", assert_errors, missing);
		if (hung || assert_errors != 0 || missing != 0) begin
			$display("CHECKS FAILED");
		end else begin
			$display("ALL CHECKS PASSED");
		end
		$finish;
	end

endmodule

/* src.f */
logic/rv_pkg.sv
logic/cpu_state_machine.sv
logic/pc_stage.sv
logic/inst_mem_read.sv
logic/decoder.sv
logic/register_file.sv
logic/execution.sv
logic/data_rw_mem.sv
logic/cpu_top.sv
tb/tb_mem_model.sv
tb/tb_cpu_top.sv

/* run.sh */
#!/bin/sh
# compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_cpu_top -f src.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
